/* flist.f */
hdl/ql_bus_pkg.sv
hdl/ql_clock_enables.sv
hdl/ql_reset_stretch.sv
hdl/ql_addr_decode.sv
hdl/ql_control_regs.sv
hdl/ql_word_ram.sv
hdl/ql_read_mux.sv
hdl/ql_bus_top.sv
verification/ql_bus_tb.sv

/* hdl/ql_addr_decode.sv */
// CPU address decoder with RAM size wrap mask and QL, GoldCard and QL-SD regions
`timescale 1ns/1ps

module ql_addr_decode (
	input  logic [23:1]          cpu_addr16,
	input  logic                 cpu_as,
	input  logic                 cpu_rw,
	input  logic                 cpu_uds,
	input  logic                 cpu_lds,
	input  ql_bus_pkg::ram_cfg_t ram_cfg,
	input  logic                 rom_shadow,
	output ql_bus_pkg::bus_addr_t cpu_addr,
	output logic                 cpu_rd,
	output logic                 cpu_wr,
	output ql_bus_pkg::region_t  region,
	output logic                 sdram_wr,
	output logic                 sdram_oe,
	output logic [23:0]          sdram_addr
);
	import ql_bus_pkg::*;

	logic      gc_en;
	bus_addr_t addr_mask;
	logic      gc_ram1, gc_ram2;
	logic      qlsd_en;
	logic      shadow_rd, shadow_wr;

	assign gc_en = (ram_cfg == RAM_4096K);

	// ========================================================================
	// Address rebuild and wrap
	// ========================================================================
	always_comb begin
		case (ram_cfg)
			RAM_128K:  addr_mask = 24'h03ffff;   // 256 KB
			RAM_4096K: addr_mask = 24'h7fffff;   // 8 MB incl. extended I/O
			default:   addr_mask = 24'h0fffff;   // 1 MB for 640k and 896k
		endcase
	end

	// A0 comes from the byte strobes, lower byte only means odd address
	assign cpu_addr = {cpu_addr16, !cpu_uds && cpu_lds} & addr_mask;

	assign cpu_rd = cpu_as && cpu_rw && (cpu_uds || cpu_lds);
	assign cpu_wr = cpu_as && !cpu_rw && (cpu_uds || cpu_lds);

	// ========================================================================
	// QL memory map
	// ========================================================================
	assign region.ql_io   = (cpu_addr[23:14] == 10'h006);
	assign region.bram    = (cpu_addr[23:17] == 7'h01);
	assign region.xram    =
		(ram_cfg == RAM_640K  && cpu_addr[23:20] == 4'h0 && ^cpu_addr[19:18]) ||  // 512k ext
		(ram_cfg == RAM_896K  && cpu_addr[23:20] == 4'h0 && |cpu_addr[19:18]) ||  // 768k ext
		(ram_cfg == RAM_4096K && cpu_addr[23:22] == 2'b00 && |cpu_addr[21:18]);
	assign region.ram     = region.bram || region.xram || gc_ram1 || gc_ram2;
	assign region.rom     = (cpu_addr[23:16] == 8'h00);
	assign region.ext_rom = (cpu_addr[23:14] == 10'h003);
	assign region.os_rom  = region.rom && !region.ext_rom;

	// GoldCard extra spaces
	assign region.gc_io       = gc_en && (cpu_addr[23:8] == 16'h01c0);
	assign gc_ram1            = gc_en && (cpu_addr[23:15] == 9'h002);       // $10000-$17fff
	assign gc_ram2            = gc_en && (cpu_addr[23:14] == 10'h007) && !region.gc_io;
	assign region.gc_boot_rom = gc_en && (cpu_addr[23:16] == 8'h04);
	assign region.gc_os_rom   = gc_en && (cpu_addr[23:16] == 8'h40);

	// QL-SD window sits in ROM space, hidden while GoldCard boot ROM is mapped
	assign qlsd_en         = (!gc_en || rom_shadow) && region.rom && cpu_rd;
	assign region.qlsd_reg = qlsd_en &&
		(cpu_addr[15:4] == 12'hfee || cpu_addr[15:4] == 12'hfef);
	assign region.qlsd_rd  = qlsd_en && (cpu_addr[15:0] == QLSD_DATA_ADDR);
	assign region.qlsd_dat = qlsd_en && (cpu_addr[15:8] == 8'hff);

	// ========================================================================
	// SDRAM strobes
	// ========================================================================
	assign shadow_rd = cpu_rd && region.os_rom && rom_shadow;          // Shadow RAM reads
	assign shadow_wr = cpu_as && !cpu_rw && region.os_rom && !rom_shadow;  // Fill shadow

	assign sdram_wr   = cpu_as && !cpu_rw && (region.ram || shadow_wr);
	assign sdram_oe   = cpu_rd && (region.ram || shadow_rd);
	assign sdram_addr = {3'b000, cpu_addr[21:1]};   // Word address

endmodule

/* hdl/ql_bus_pkg.sv */
// QL bus package with shared bus types, speed and RAM encodings, divider constants
package ql_bus_pkg;

	typedef logic [23:0] bus_addr_t;         // 68008 byte address
	typedef logic [15:0] bus_word_t;         // Data word on the bus

	// CPU speed select
	typedef enum logic [1:0] {
		SPEED_QL,                            // Original 7.5 MHz class
		SPEED_16,
		SPEED_24,
		SPEED_FULL
	} cpu_speed_t;

	// RAM size select, top value also turns on GoldCard mode
	typedef enum logic [1:0] {
		RAM_128K,
		RAM_640K,
		RAM_896K,
		RAM_4096K
	} ram_cfg_t;

	// One strobe per decoded region
	typedef struct packed {
		logic ql_io;                         // $18000-$1bfff
		logic bram;                          // Base 128k RAM
		logic xram;                          // Expansion RAM banks
		logic ram;                           // Any RAM at all
		logic rom;                           // $0000-$ffff
		logic ext_rom;                       // $c000-$ffff
		logic os_rom;                        // $0000-$bfff
		logic gc_io;                         // $1c000-$1c0ff
		logic gc_boot_rom;                   // $040000-$04ffff
		logic gc_os_rom;                     // $400000-$40ffff
		logic qlsd_reg;
		logic qlsd_rd;                       // The one register that returns data
		logic qlsd_dat;
	} region_t;

	// Divider table for an 84 MHz clk_sys
	localparam logic [3:0] DIV_BUS_QL   = 4'd11;    // 7.64 MHz
	localparam logic [3:0] DIV_BUS_16   = 4'd5;     // 16.8 MHz
	localparam logic [3:0] DIV_BUS_24   = 4'd3;     // 28 MHz
	localparam logic [3:0] DIV_BUS_FULL = 4'd2;     // 42 MHz
	localparam logic [9:0] DIV_REFRESH  = 10'd640;  // 131.25 kHz refresh and RTC tick
	localparam logic [3:0] DIV_VID      = 4'd8;     // 10.5 MHz pixel tick

	// GoldCard I/O offsets and the QL-SD data register
	localparam logic [7:0]  GC_SHADOW_ON   = 8'h60;
	localparam logic [7:0]  GC_SHADOW_OFF  = 8'h64;
	localparam logic [15:0] QLSD_DATA_ADDR = 16'hfee4;

endpackage

/* hdl/ql_bus_top.sv */
// QL system bus core top level tying clocking, reset, decode, registers and memories
`timescale 1ns/1ps

module ql_bus_top #(
	parameter int RESET_PHASES = 4095,
	parameter int ADDR_W       = 15
) (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   reset_req,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	input  ql_bus_pkg::ram_cfg_t   ram_cfg_sel,
	// CPU bus, active high strobes
	input  logic [23:1]            cpu_addr16,
	input  logic                   cpu_as,
	input  logic                   cpu_rw,
	input  logic                   cpu_uds,
	input  logic                   cpu_lds,
	input  ql_bus_pkg::bus_word_t  cpu_dout,
	// OS ROM download
	input  logic                   rom_dl_wr,
	input  logic [ADDR_W-1:0]      rom_dl_addr,
	input  ql_bus_pkg::bus_word_t  rom_dl_data,
	// Video fetch
	input  logic [ADDR_W-1:0]      video_addr,
	output ql_bus_pkg::bus_word_t  vram_dout,
	// External sources
	input  ql_bus_pkg::bus_word_t  sdram_dout,
	input  logic                   sdram_dtack,
	input  logic [7:0]             qlsd_dout,
	input  logic                   qlsd_dtack,
	input  ql_bus_pkg::bus_word_t  zx8302_dout,
	input  logic [7:0]             qimi_data,
	input  ql_bus_pkg::bus_word_t  gc_rom_dout,
	input  logic                   ram_delay_dtack,
	output ql_bus_pkg::bus_word_t  cpu_din,
	output logic                   cpu_dtack,
	output logic                   sdram_wr,
	output logic                   sdram_oe,
	output logic [23:0]            sdram_addr,
	output logic                   zx8302_sel,
	output logic                   qimi_sel,
	output logic [7:0]             mc_stat,
	output logic                   core_reset,
	output logic                   ce_bus_p,
	output logic                   ce_bus_n,
	output logic                   ce_refresh,
	output logic                   ce_vid
);
	import ql_bus_pkg::*;

	bus_addr_t cpu_addr;
	logic      cpu_rd, cpu_wr, cpu_io;
	region_t   region;
	ram_cfg_t  ram_cfg;
	logic      rom_shadow;
	bus_word_t ql_rom_dout;

	assign cpu_io = cpu_rd || cpu_wr;

	ql_clock_enables ql_clock_enables_i (
		.clk_sys, .reset, .cpu_speed,
		.ce_bus_p, .ce_bus_n, .ce_refresh, .ce_vid
	);

	ql_reset_stretch #(.RESET_PHASES(RESET_PHASES)) ql_reset_stretch_i (
		.clk_sys, .reset, .reset_req, .ce_bus_p, .core_reset
	);

	ql_addr_decode ql_addr_decode_i (
		.cpu_addr16, .cpu_as, .cpu_rw, .cpu_uds, .cpu_lds, .ram_cfg, .rom_shadow,
		.cpu_addr, .cpu_rd, .cpu_wr, .region, .sdram_wr, .sdram_oe, .sdram_addr
	);

	ql_control_regs ql_control_regs_i (
		.clk_sys, .core_reset, .ram_cfg_sel, .cpu_addr, .cpu_wr, .cpu_uds, .cpu_lds,
		.cpu_dout, .region, .ram_cfg, .rom_shadow, .mc_stat
	);

	// OS ROM, filled only through the download port
	ql_word_ram #(.ADDR_W(ADDR_W)) ql_rom (
		.clk_sys, .wr_addr(rom_dl_addr), .wr_en(rom_dl_wr), .byte_en(2'b11),
		.wr_data(rom_dl_data), .rd_addr(cpu_addr[ADDR_W:1]), .rd_data(ql_rom_dout)
	);

	// Screen memory at $20000, CPU writes and video reads
	ql_word_ram #(.ADDR_W(ADDR_W)) vram (
		.clk_sys, .wr_addr(cpu_addr[ADDR_W:1]),
		.wr_en(cpu_wr && cpu_addr[23:16] == 8'h02),
		.byte_en({cpu_uds, cpu_lds}), .wr_data(cpu_dout),
		.rd_addr(video_addr), .rd_data(vram_dout)
	);

	ql_read_mux ql_read_mux_i (
		.region, .cpu_addr, .ram_cfg, .rom_shadow, .cpu_io, .sdram_wr, .sdram_oe,
		.ql_rom_dout, .gc_rom_dout, .sdram_dout, .zx8302_dout, .qimi_data, .qlsd_dout,
		.sdram_dtack, .qlsd_dtack, .ram_delay_dtack,
		.zx8302_sel, .qimi_sel, .cpu_din, .cpu_dtack
	);

endmodule

/* hdl/ql_clock_enables.sv */
// Bus phase, refresh and pixel clock enable generator running off clk_sys
`timescale 1ns/1ps

module ql_clock_enables (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  ql_bus_pkg::cpu_speed_t cpu_speed,
	output logic                   ce_bus_p,   // Phi1 enable
	output logic                   ce_bus_n,   // Phi2 enable
	output logic                   ce_refresh,
	output logic                   ce_vid
);
	import ql_bus_pkg::*;

	logic [3:0] bus_cnt;
	logic [9:0] ref_cnt;
	logic [3:0] vid_cnt;
	logic [3:0] bus_div;     // Current bus divider

	// Divider picked from the speed select each cycle
	always_comb begin
		case (cpu_speed)
			SPEED_QL:   bus_div = DIV_BUS_QL;
			SPEED_16:   bus_div = DIV_BUS_16;
			SPEED_24:   bus_div = DIV_BUS_24;
			default:    bus_div = DIV_BUS_FULL;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			bus_cnt    <= '0;
			ref_cnt    <= '0;
			vid_cnt    <= '0;
			ce_bus_p   <= 1'b0;
			ce_bus_n   <= 1'b0;
			ce_refresh <= 1'b0;
			ce_vid     <= 1'b0;
		end else begin
			// >= so a speed drop mid-count wraps at once
			bus_cnt <= (bus_cnt >= bus_div - 4'd1) ? 4'd0 : bus_cnt + 4'd1;
			ref_cnt <= (ref_cnt == DIV_REFRESH - 10'd1) ? 10'd0 : ref_cnt + 10'd1;
			vid_cnt <= (vid_cnt == DIV_VID - 4'd1) ? 4'd0 : vid_cnt + 4'd1;

			ce_bus_p   <= (bus_cnt == 4'd0);
			ce_bus_n   <= (bus_cnt == (bus_div >> 1));   // Half period later
			ce_refresh <= (ref_cnt == 10'd0);
			ce_vid     <= (vid_cnt == 4'd0);
		end
	end

endmodule

/* hdl/ql_control_regs.sv */
// RAM size latch, GoldCard shadow flag and ZX8301 display control register
`timescale 1ns/1ps

module ql_control_regs (
	input  logic                  clk_sys,
	input  logic                  core_reset,
	input  ql_bus_pkg::ram_cfg_t  ram_cfg_sel,
	input  ql_bus_pkg::bus_addr_t cpu_addr,
	input  logic                  cpu_wr,
	input  logic                  cpu_uds,
	input  logic                  cpu_lds,
	input  ql_bus_pkg::bus_word_t cpu_dout,
	input  ql_bus_pkg::region_t   region,
	output ql_bus_pkg::ram_cfg_t  ram_cfg,
	output logic                  rom_shadow,
	output logic [7:0]            mc_stat
);
	import ql_bus_pkg::*;

	logic gc_wr;       // Upper byte only write to GoldCard I/O
	logic disp_wr;     // Write-only display register at $18063

	assign gc_wr   = region.gc_io && cpu_wr && cpu_uds && !cpu_lds;
	assign disp_wr = region.ql_io && ({cpu_addr[6:5], cpu_addr[1]} == 3'b111) &&
		cpu_wr && cpu_lds;

	// Size only changes while the core is held in reset
	always_ff @(posedge clk_sys) begin
		if (core_reset)
			ram_cfg <= ram_cfg_sel;
	end

	always_ff @(posedge clk_sys) begin
		if (core_reset) begin
			rom_shadow <= 1'b0;
			mc_stat    <= 8'h00;
		end else begin
			if (gc_wr && cpu_addr[7:0] == GC_SHADOW_ON)
				rom_shadow <= 1'b1;                 // Shadow RAM over OS ROM
			else if (gc_wr && cpu_addr[7:0] == GC_SHADOW_OFF)
				rom_shadow <= 1'b0;                 // Back to boot mapping
			if (disp_wr)
				mc_stat <= cpu_dout[7:0];           // Mode, blank and screen select
		end
	end

endmodule

/* hdl/ql_read_mux.sv */
// CPU read data multiplexer with peripheral selects and DTACK selection
`timescale 1ns/1ps

module ql_read_mux (
	input  ql_bus_pkg::region_t   region,
	input  ql_bus_pkg::bus_addr_t cpu_addr,
	input  ql_bus_pkg::ram_cfg_t  ram_cfg,
	input  logic                  rom_shadow,
	input  logic                  cpu_io,
	input  logic                  sdram_wr,
	input  logic                  sdram_oe,
	input  ql_bus_pkg::bus_word_t ql_rom_dout,
	input  ql_bus_pkg::bus_word_t gc_rom_dout,
	input  ql_bus_pkg::bus_word_t sdram_dout,
	input  ql_bus_pkg::bus_word_t zx8302_dout,
	input  logic [7:0]            qimi_data,
	input  logic [7:0]            qlsd_dout,
	input  logic                  sdram_dtack,
	input  logic                  qlsd_dtack,
	input  logic                  ram_delay_dtack,
	output logic                  zx8302_sel,
	output logic                  qimi_sel,
	output ql_bus_pkg::bus_word_t cpu_din,
	output logic                  cpu_dtack
);
	import ql_bus_pkg::*;

	logic      gc_en;
	logic      shadow_acc;      // OS ROM access that goes to SDRAM
	bus_word_t io_dout;
	bus_word_t gc_boot_dout;
	bus_word_t gc_shadow_dout;
	bus_word_t ql_dout;

	assign gc_en = (ram_cfg == RAM_4096K);

	// Peripheral selects inside $18000-$1bfff
	assign zx8302_sel = cpu_io && region.ql_io && !cpu_addr[6];
	assign qimi_sel   = cpu_io && region.ql_io && (cpu_addr[13:8] == 6'h3f);  // $1bfxx

	// ========================================================================
	// Data bus priorities
	// ========================================================================
	assign io_dout = qimi_sel   ? {qimi_data, qimi_data} :
	                 zx8302_sel ? zx8302_dout :
	                 16'h0000;

	// GoldCard booting, shadow RAM off
	assign gc_boot_dout = region.rom         ? gc_rom_dout :
	                      region.gc_boot_rom ? gc_rom_dout :    // Second boot ROM copy
	                      region.gc_os_rom   ? ql_rom_dout :    // QL ROM moved up
	                      region.ram         ? sdram_dout :
	                      16'hffff;

	// GoldCard running from shadow RAM
	assign gc_shadow_dout = region.os_rom    ? sdram_dout :
	                        region.qlsd_rd   ? {qlsd_dout, qlsd_dout} :
	                        region.ext_rom   ? ql_rom_dout :
	                        region.gc_os_rom ? ql_rom_dout :
	                        region.ram       ? sdram_dout :
	                        16'hffff;

	// Plain QL
	assign ql_dout = region.qlsd_rd ? {qlsd_dout, qlsd_dout} :
	                 region.rom     ? ql_rom_dout :
	                 region.ram     ? sdram_dout :
	                 16'hffff;                           // Nothing mapped

	always_comb begin
		if (region.ql_io)
			cpu_din = io_dout;          // I/O wins in every mode
		else if (gc_en)
			cpu_din = rom_shadow ? gc_shadow_dout : gc_boot_dout;
		else
			cpu_din = ql_dout;
	end

	// ========================================================================
	// DTACK
	// ========================================================================
	assign shadow_acc = region.os_rom && (rom_shadow ? sdram_oe : sdram_wr);

	always_comb begin
		if (region.qlsd_reg || region.qlsd_dat)
			cpu_dtack = qlsd_dtack;
		else if (shadow_acc)
			cpu_dtack = sdram_dtack;
		else if (region.ram)
			cpu_dtack = sdram_dtack && !ram_delay_dtack;   // QL RAM contention
		else
			cpu_dtack = 1'b1;
	end

endmodule

/* hdl/ql_reset_stretch.sv */
// Reset stretcher that holds the core in reset for a number of bus phases
`timescale 1ns/1ps

module ql_reset_stretch #(
	parameter int RESET_PHASES = 4095
) (
	input  logic clk_sys,
	input  logic reset,
	input  logic reset_req,      // Button, OSD or ROM download
	input  logic ce_bus_p,
	output logic core_reset
);

	localparam int CNT_W = $clog2(RESET_PHASES + 1);

	logic [CNT_W-1:0] phase_cnt;

	always_ff @(posedge clk_sys) begin
		if (reset || reset_req)
			phase_cnt <= CNT_W'(RESET_PHASES);       // Reload on every request
		else if (ce_bus_p && phase_cnt != '0)
			phase_cnt <= phase_cnt - 1'b1;           // Count down per bus phase
	end

	assign core_reset = (phase_cnt != '0);

endmodule

/* hdl/ql_word_ram.sv */
// Simple dual-port word memory with byte write enables and registered read
`timescale 1ns/1ps

module ql_word_ram #(
	parameter int ADDR_W = 15
) (
	input  logic                  clk_sys,
	input  logic [ADDR_W-1:0]     wr_addr,
	input  logic                  wr_en,
	input  logic [1:0]            byte_en,    // [1] upper, [0] lower
	input  ql_bus_pkg::bus_word_t wr_data,
	input  logic [ADDR_W-1:0]     rd_addr,
	output ql_bus_pkg::bus_word_t rd_data
);
	import ql_bus_pkg::*;

	bus_word_t mem [2**ADDR_W];

	always_ff @(posedge clk_sys) begin
		if (wr_en && byte_en[1])
			mem[wr_addr][15:8] <= wr_data[15:8];
		if (wr_en && byte_en[0])
			mem[wr_addr][7:0] <= wr_data[7:0];
		rd_data <= mem[rd_addr];                  // One cycle read latency
	end

endmodule

/* run_sim.sh */
#!/bin/sh
# Build and run the QL bus testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module ql_bus_tb -f flist.f -o ql_bus_sim
./obj_dir/ql_bus_sim 2>&1 | tee sim.log
if grep -q "RESULT: FAIL" sim.log; then
	echo "Simulation failed"
	exit 1
fi
echo "Simulation finished without failures"

/* verification/ql_bus_stimulus.txt */
// op: 0 download, 1 write, 2 read, 3 speed, 4 video fetch; strb is {uds,lds}; cfg is ram_cfg
// op addr data strb cfg  exp dtack oe wr sel{qimi,zx}; exp is read data, mc_stat or pulse gap
3 000000 0000 0 0 000b 0 0 0 0
3 000000 0001 0 0 0005 0 0 0 0
3 000000 0002 0 0 0003 0 0 0 0
3 000000 0003 0 0 0002 0 0 0 0
0 000100 1234 3 0 0000 0 0 0 0
0 000102 abcd 3 0 0000 0 0 0 0
2 000100 0000 3 0 1234 1 0 0 0
2 000102 0000 3 0 abcd 1 0 0 0
2 00fee4 0000 3 0 4747 0 0 0 0
2 010000 0000 3 0 ffff 1 0 0 0
2 028000 0000 3 0 51a3 0 1 0 0
2 068000 0000 3 0 51a3 0 1 0 0
2 0c0000 0000 3 1 ffff 1 0 0 0
2 080000 0000 3 1 51a3 0 1 0 0
2 180000 0000 3 1 51a3 0 1 0 0
2 0c0000 0000 3 2 51a3 0 1 0 0
2 128000 0000 3 2 51a3 0 1 0 0
2 000100 0000 3 3 6c0b 1 0 0 0
1 000100 5555 3 3 0000 1 0 1 0
2 400102 0000 3 3 abcd 1 0 0 0
1 01c060 0000 2 3 0000 1 0 0 0
2 000100 0000 3 3 51a3 1 1 0 0
2 00fee4 0000 3 3 4747 0 0 0 0
1 01c064 0000 2 3 0000 1 0 0 0
2 000100 0000 3 3 6c0b 1 0 0 0
2 300000 0000 3 3 51a3 0 1 0 0
2 900000 0000 3 3 51a3 0 1 0 0
1 018063 00a5 1 3 00a5 1 0 0 0
2 018020 0000 3 3 2e81 1 0 0 1
2 01bf40 0000 3 3 9c9c 1 0 0 2
1 020010 7e3c 3 3 00a5 0 0 1 0
4 000008 0000 0 3 7e3c 0 0 0 0
1 020011 0099 1 3 00a5 0 0 1 0
4 000008 0000 0 3 7e99 0 0 0 0

/* verification/ql_bus_tb.sv */
// Testbench for the QL bus core, replays CPU bus operations from a stimulus file
`timescale 1ns/1ps

module ql_bus_tb;
	import ql_bus_pkg::*;

	localparam int TB_PHASES  = 16;                  // Short reset stretch
	localparam int FIELDS     = 10;                  // Words per stimulus line
	localparam int MAX_LINES  = 64;
	localparam int RESET_TIME = 8 + (TB_PHASES + 2) * 11 + 32;
	localparam int OP_DL      = 0;                   // ROM download
	localparam int OP_WR      = 1;
	localparam int OP_RD      = 2;
	localparam int OP_SPEED   = 3;
	localparam int OP_VID     = 4;                   // Video fetch from VRAM

	// Fixed answers from the external bus sources
	localparam bus_word_t  SDRAM_PAT  = 16'h51a3;
	localparam bus_word_t  GC_ROM_PAT = 16'h6c0b;
	localparam bus_word_t  ZX_PAT     = 16'h2e81;
	localparam logic [7:0] QIMI_PAT   = 8'h9c;
	localparam logic [7:0] QLSD_PAT   = 8'h47;

	logic        clk_sys = 1'b0;
	logic        reset, reset_req;
	cpu_speed_t  cpu_speed;
	ram_cfg_t    ram_cfg_sel;
	logic [23:1] cpu_addr16;
	logic        cpu_as, cpu_rw, cpu_uds, cpu_lds;
	bus_word_t   cpu_dout;
	logic        rom_dl_wr;
	logic [14:0] rom_dl_addr;
	bus_word_t   rom_dl_data;
	logic [14:0] video_addr;
	bus_word_t   vram_dout;
	bus_word_t   sdram_dout, zx8302_dout, gc_rom_dout;
	logic        sdram_dtack, qlsd_dtack, ram_delay_dtack;
	logic [7:0]  qlsd_dout, qimi_data;
	bus_word_t   cpu_din;
	logic        cpu_dtack, sdram_wr, sdram_oe, zx8302_sel, qimi_sel;
	logic [23:0] sdram_addr;
	logic [7:0]  mc_stat;
	logic        core_reset, ce_bus_p, ce_bus_n, ce_refresh, ce_vid;

	int          n_lines;
	logic [31:0] stim [MAX_LINES*FIELDS];
	ram_cfg_t    cur_cfg;                            // Size latched in the DUT

	always #4 clk_sys = ~clk_sys;                    // 8 ns period

	// All port names match the local signals
	ql_bus_top #(.RESET_PHASES(TB_PHASES)) ql_bus_top_i (.*);

	task automatic report_fail(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1, "Stopped at the first failure");
	endtask

	task automatic check_word(input string what, input bus_word_t got, input bus_word_t exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp));
	endtask

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_addr(input string what, input bus_addr_t got, input bus_addr_t exp);
		if (got !== exp)
			report_fail($sformatf("Error at %0t ns: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp)
			report_fail($sformatf("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	// Top of the CPU address space for each RAM size
	function automatic bus_addr_t wrap_mask(input ram_cfg_t cfg);
		case (cfg)
			RAM_128K:  return (24'd256 << 10) - 24'd1;   // 256 KB
			RAM_4096K: return (24'd8 << 20) - 24'd1;     // 8 MB
			default:   return (24'd1 << 20) - 24'd1;     // 1 MB
		endcase
	endfunction

	// Acknowledge, SDRAM strobes and peripheral selects of one access
	task automatic check_strobes(input string tag, input bus_addr_t addr,
		input logic [31:0] dtack, oe, wr, sel);
		check_bit({tag, " cpu_dtack"}, cpu_dtack, dtack[0]);
		check_bit({tag, " sdram_oe"}, sdram_oe, oe[0]);
		check_bit({tag, " sdram_wr"}, sdram_wr, wr[0]);
		check_bit({tag, " qimi_sel"}, qimi_sel, sel[1]);
		check_bit({tag, " zx8302_sel"}, zx8302_sel, sel[0]);
		if (oe[0] || wr[0])
			check_addr({tag, " sdram_addr"}, sdram_addr, (addr & wrap_mask(cur_cfg)) >> 1);
		// SDRAM not ready and no contention, SDRAM accesses must now wait
		@(posedge clk_sys);
		sdram_dtack     <= 1'b0;
		ram_delay_dtack <= 1'b0;
		@(negedge clk_sys);
		check_bit({tag, " cpu_dtack with SDRAM busy"}, cpu_dtack,
			dtack[0] && !(oe[0] || wr[0]));
	endtask

	// Cycles between two pulses of ce_bus_p, or of ce_vid
	task automatic measure_gap(input bit vid, output int gap);
		gap = 0;
		do begin
			@(negedge clk_sys);
		end while (!(vid ? ce_vid : ce_bus_p));
		do begin
			@(negedge clk_sys);
			gap++;
		end while (!(vid ? ce_vid : ce_bus_p));
	endtask

	task automatic bus_drive(input bit write, input logic [23:0] addr, input bus_word_t data,
		input logic [1:0] strb);
		@(posedge clk_sys);
		cpu_addr16 <= addr[23:1];
		cpu_as     <= 1'b1;
		cpu_rw     <= !write;
		cpu_uds    <= strb[1];
		cpu_lds    <= strb[0];
		cpu_dout   <= data;
	endtask

	task automatic bus_release();
		@(posedge clk_sys);
		cpu_as          <= 1'b0;
		cpu_rw          <= 1'b1;
		cpu_uds         <= 1'b0;
		cpu_lds         <= 1'b0;
		sdram_dtack     <= 1'b1;
		ram_delay_dtack <= 1'b1;
	endtask

	// New RAM size only latches while core_reset is high
	task automatic apply_cfg(input ram_cfg_t cfg);
		@(posedge clk_sys);
		ram_cfg_sel <= cfg;
		reset_req   <= 1'b1;
		@(posedge clk_sys);
		reset_req   <= 1'b0;
		@(negedge clk_sys);
		check_bit("core_reset after request", core_reset, 1'b1);
		while (core_reset)
			@(negedge clk_sys);
		cur_cfg = cfg;
	endtask

	// Watchdog, 64 cycles per operation plus the reset stretch
	initial begin
		#1;
		repeat (n_lines * 64 + RESET_TIME)
			@(posedge clk_sys);
		report_fail("Timeout: the run did not finish in the expected number of cycles");
	end

	initial begin
		int          gap;
		int          pulses;
		logic [31:0] f [FIELDS];
		string       tag;

		reset           = 1'b1;
		reset_req       = 1'b0;
		cpu_speed       = SPEED_QL;
		ram_cfg_sel     = RAM_128K;
		cpu_addr16      = '0;
		cpu_as          = 1'b0;
		cpu_rw          = 1'b1;
		cpu_uds         = 1'b0;
		cpu_lds         = 1'b0;
		cpu_dout        = '0;
		rom_dl_wr       = 1'b0;
		rom_dl_addr     = '0;
		rom_dl_data     = '0;
		video_addr      = '0;
		sdram_dout      = SDRAM_PAT;
		zx8302_dout     = ZX_PAT;
		gc_rom_dout     = GC_ROM_PAT;
		qlsd_dout       = QLSD_PAT;
		qimi_data       = QIMI_PAT;
		sdram_dtack     = 1'b1;
		qlsd_dtack      = 1'b0;
		ram_delay_dtack = 1'b1;                      // RAM held off by contention
		cur_cfg         = RAM_128K;

		// Unread slots keep all ones and mark the end
		for (int i = 0; i < MAX_LINES * FIELDS; i++)
			stim[i] = '1;
		$readmemh("verification/ql_bus_stimulus.txt", stim);
		n_lines = 0;
		while (n_lines < MAX_LINES && stim[n_lines * FIELDS] != '1)
			n_lines++;
		if (n_lines == 0)
			report_fail("Stimulus file is missing or holds no operations");

		// ====================================================================
		// Reset and reset stretch
		// ====================================================================
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_sys);
			if (i == 7)
				reset <= 1'b0;
			@(negedge clk_sys);
			check_bit("ce_bus_p in reset", ce_bus_p, 1'b0);
			check_bit("ce_bus_n in reset", ce_bus_n, 1'b0);
			check_bit("ce_refresh in reset", ce_refresh, 1'b0);
			check_bit("ce_vid in reset", ce_vid, 1'b0);
		end
		pulses = 0;
		while (core_reset) begin
			if (ce_bus_p)
				pulses++;
			@(negedge clk_sys);
		end
		check_count("bus phases in core reset", pulses, TB_PHASES);
		check_byte("mc_stat after reset", mc_stat, 8'h00);
		measure_gap(1'b1, gap);
		check_count("ce_vid gap", gap, 8);

		// ====================================================================
		// Stimulus replay
		// ====================================================================
		for (int ln = 0; ln < n_lines; ln++) begin
			for (int k = 0; k < FIELDS; k++)
				f[k] = stim[ln * FIELDS + k];
			tag = $sformatf("op %0d", ln + 1);
			if (ram_cfg_t'(f[4][1:0]) != cur_cfg)
				apply_cfg(ram_cfg_t'(f[4][1:0]));
			case (f[0])
				OP_DL: begin
					@(posedge clk_sys);
					rom_dl_wr   <= 1'b1;
					rom_dl_addr <= f[1][15:1];       // Word address
					rom_dl_data <= f[2][15:0];
					@(posedge clk_sys);
					rom_dl_wr   <= 1'b0;
				end
				OP_WR: begin
					bus_drive(1'b1, f[1][23:0], f[2][15:0], f[3][1:0]);
					@(negedge clk_sys);
					check_strobes(tag, f[1][23:0], f[6], f[7], f[8], f[9]);
					bus_release();
					@(negedge clk_sys);
					check_byte({tag, " mc_stat"}, mc_stat, f[5][7:0]);
				end
				OP_RD: begin
					bus_drive(1'b0, f[1][23:0], 16'h0000, f[3][1:0]);
					@(posedge clk_sys);              // ROM data is one cycle late
					@(negedge clk_sys);
					check_word({tag, " cpu_din"}, cpu_din, f[5][15:0]);
					check_strobes(tag, f[1][23:0], f[6], f[7], f[8], f[9]);
					bus_release();
				end
				OP_SPEED: begin
					@(posedge clk_sys);
					cpu_speed <= cpu_speed_t'(f[2][1:0]);
					measure_gap(1'b0, gap);          // May straddle the change
					measure_gap(1'b0, gap);
					check_count({tag, " ce_bus_p gap"}, gap, int'(f[5]));
					measure_gap(1'b1, gap);
					check_count({tag, " ce_vid gap"}, gap, 8);
				end
				OP_VID: begin
					@(posedge clk_sys);
					video_addr <= f[1][14:0];
					@(posedge clk_sys);
					@(negedge clk_sys);
					check_word({tag, " vram_dout"}, vram_dout, f[5][15:0]);
				end
				default:
					report_fail($sformatf("Unknown operation code %0d in the stimulus", f[0]));
			endcase
		end

		repeat (2)
			@(posedge clk_sys);
		$display("RESULT: PASS");
		$finish;
	end

endmodule
